/* rtl/bus_pkg.sv */
package bus_pkg;

    localparam int DATA_WIDTH   = 16;
    localparam int SLAVE_COUNT  = 3;
    localparam int MASTER_COUNT = 2;                // internal masters only

    // slave id k maps to entry k-1
    localparam int SLAVE_DEPTHS [SLAVE_COUNT] = '{4096, 4096, 2048};

    localparam int ADDR_WIDTH   = 12;               // covers the deepest slave

    typedef logic [DATA_WIDTH-1:0] word_t;
    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [1:0]            slave_id_t;      // 0 = master idle, 1..3 = slave

endpackage

/* rtl/ctrl_pkg.sv */
package ctrl_pkg;

    localparam int BANK_DEPTH    = 16;              // write words per master
    localparam int COM_START_GAP = 4;               // cycles between start[0] and start[1]

    // one extra bit so a full bank count fits
    typedef logic [$clog2(BANK_DEPTH):0] bank_idx_t;

    typedef enum logic [3:0] {
        st_slave_sel,
        st_dir_sel,
        st_bank_sel,
        st_bank_m0,
        st_bank_m1,
        st_first_m0,
        st_first_m1,
        st_len_m0,
        st_len_m1,
        st_config,
        st_ready,
        st_run,
        st_done
    } menu_state_e;

    typedef enum logic [2:0] {
        op_none,
        op_slave,
        op_dir,
        op_bank_en,
        op_bank_word,
        op_first,
        op_length,
        op_send
    } setup_op_e;

    typedef struct packed {
        setup_op_e      op;
        bus_pkg::word_t value;
    } setup_cmd_t;

    typedef enum logic {
        kind_head,
        kind_word
    } xfer_kind_e;

    typedef struct packed {
        bus_pkg::slave_id_t slave_id;
        logic               read;                   // 1 read, 0 write
        logic               burst;
        bus_pkg::addr_t     first_addr;
        bus_pkg::addr_t     last_addr;
    } master_cfg_t;

    typedef struct packed {
        xfer_kind_e     kind;
        master_cfg_t    cfg;
        bus_pkg::word_t data;
    } setup_xfer_t;

    typedef struct packed {
        logic idle;
        logic ready;
        logic running;
        logic done;
    } lights_t;

endpackage

/* rtl/master_setup.sv */
`timescale 1ns/1ps

module master_setup (
    input  logic                  clk,
    input  logic                  rstN,
    input  ctrl_pkg::setup_cmd_t  cmd,
    output logic                  configured,
    output logic                  req,
    output ctrl_pkg::setup_xfer_t xfer,
    input  logic                  ack
);
    import bus_pkg::*;
    import ctrl_pkg::*;

    typedef enum logic [2:0] {
        xs_idle,
        xs_launch,
        xs_wait_ack,
        xs_wait_low,
        xs_done
    } xfer_state_e;

    typedef logic [DATA_WIDTH:0] sum_t;             // room for first + length overflow

    xfer_state_e state;
    master_cfg_t cfg;
    logic        bank_en;
    bank_idx_t   count;                             // words stored so far
    bank_idx_t   pos;                               // word currently on the channel
    logic        head_sent;
    logic        more_items;
    word_t       bank [BANK_DEPTH];
    sum_t        len_sum;
    sum_t        last_limit;
    addr_t       clamped_last;

    // last address of the chosen slave, then clamp first + length to it
    always_comb begin
        last_limit = '0;
        for (int k = 0; k < SLAVE_COUNT; k++) begin
            if (cfg.slave_id == slave_id_t'(k + 1)) begin
                last_limit = sum_t'(SLAVE_DEPTHS[k] - 1);
            end
        end
        len_sum      = sum_t'(cfg.first_addr) + sum_t'(cmd.value);
        clamped_last = (len_sum > last_limit) ? addr_t'(last_limit) : addr_t'(len_sum);
    end

    always_comb begin
        if (!head_sent) begin
            more_items = bank_en && (count != '0);  // words follow the head
        end else begin
            more_items = (pos + 1'b1) < count;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            cfg     <= '0;
            bank_en <= 1'b0;
            count   <= '0;
        end else begin
            case (cmd.op)
                op_slave: begin
                    cfg.slave_id <= slave_id_t'(cmd.value);
                end
                op_dir: begin
                    cfg.read <= cmd.value[0];
                end
                op_bank_en: begin
                    bank_en <= cmd.value[0];
                end
                op_bank_word: begin
                    if (count < bank_idx_t'(BANK_DEPTH)) begin  // saturate when full
                        count <= count + 1'b1;
                        if (count != '0) begin
                            cfg.burst <= 1'b1;              // second word makes it a burst
                        end
                    end
                end
                op_first: begin
                    cfg.first_addr <= addr_t'(cmd.value);
                end
                op_length: begin
                    cfg.last_addr <= clamped_last;
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cmd.op == op_bank_word && count < bank_idx_t'(BANK_DEPTH)) begin
            bank[count[$clog2(BANK_DEPTH)-1:0]] <= cmd.value;
        end
    end

    // four-phase transfer, head first then the bank words in order
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state      <= xs_idle;
            req        <= 1'b0;
            configured <= 1'b0;
            head_sent  <= 1'b0;
            pos        <= '0;
        end else begin
            case (state)
                xs_idle: begin
                    if (cmd.op == op_send) begin
                        head_sent <= 1'b0;
                        pos       <= '0;
                        state     <= xs_launch;
                    end
                end
                xs_launch: begin
                    if (!ack) begin                 // previous item fully released
                        req   <= 1'b1;
                        state <= xs_wait_ack;
                    end
                end
                xs_wait_ack: begin
                    if (ack) begin
                        req   <= 1'b0;
                        state <= xs_wait_low;
                    end
                end
                xs_wait_low: begin
                    if (!ack) begin
                        head_sent <= 1'b1;
                        if (head_sent) begin
                            pos <= pos + 1'b1;
                        end
                        if (more_items) begin
                            state <= xs_launch;
                        end else begin
                            configured <= 1'b1;
                            state      <= xs_done;
                        end
                    end
                end
                xs_done: begin                      // held until reset
                end
                default: begin
                    state <= xs_idle;
                end
            endcase
        end
    end

    // item is loaded together with the rising req
    always_ff @(posedge clk) begin
        if (state == xs_launch && !ack) begin
            xfer.kind <= head_sent ? kind_word : kind_head;
            xfer.cfg  <= cfg;
            xfer.data <= head_sent ? bank[pos[$clog2(BANK_DEPTH)-1:0]] : '0;
        end
    end

endmodule

/* rtl/session_ctrl.sv */
`timescale 1ns/1ps

module session_ctrl (
    input  logic                                             clk,
    input  logic                                             rstN,
    input  logic                                             step,
    input  logic                                             next_word,
    input  bus_pkg::word_t                                   sw,
    output ctrl_pkg::setup_cmd_t [bus_pkg::MASTER_COUNT-1:0] cmd,
    input  logic [bus_pkg::MASTER_COUNT-1:0]                 configured,
    output logic [bus_pkg::MASTER_COUNT-1:0]                 start,
    input  logic [bus_pkg::MASTER_COUNT-1:0]                 com_done,
    output ctrl_pkg::lights_t                                lights
);
    import bus_pkg::*;
    import ctrl_pkg::*;

    typedef logic [$clog2(COM_START_GAP+1)-1:0] gap_cnt_t;

    menu_state_e             state;
    logic [MASTER_COUNT-1:0] selected;              // masters with a slave chosen
    logic                    bank_en_m1;            // master 1 has words to enter
    logic                    send_issued;
    gap_cnt_t                gap_cnt;
    logic                    gap_run;
    logic                    all_configured;
    logic                    all_done;

    function automatic setup_cmd_t make_cmd(setup_op_e op, word_t value);
        setup_cmd_t c;
        c.op    = op;
        c.value = value;
        return c;
    endfunction

    // unselected masters never hold the session back
    assign all_configured = &(configured | ~selected);
    assign all_done       = &(com_done | ~selected);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state       <= st_slave_sel;
            selected    <= '0;
            bank_en_m1  <= 1'b0;
            send_issued <= 1'b0;
            cmd         <= '0;
        end else begin
            for (int m = 0; m < MASTER_COUNT; m++) begin
                cmd[m] <= make_cmd(op_none, '0);    // commands last one cycle
            end
            case (state)
                st_slave_sel: begin
                    if (step) begin
                        if (sw[2*MASTER_COUNT-1:0] == '0) begin
                            state <= st_done;       // no master has work
                        end else begin
                            for (int m = 0; m < MASTER_COUNT; m++) begin
                                selected[m] <= (sw[2*m +: 2] != 2'b00);
                                cmd[m]      <= make_cmd(op_slave, word_t'(sw[2*m +: 2]));
                            end
                            state <= st_dir_sel;
                        end
                    end
                end
                st_dir_sel: begin
                    if (step) begin
                        for (int m = 0; m < MASTER_COUNT; m++) begin
                            cmd[m] <= make_cmd(op_dir, word_t'(sw[m]));
                        end
                        state <= st_bank_sel;
                    end
                end
                st_bank_sel: begin
                    if (step) begin
                        for (int m = 0; m < MASTER_COUNT; m++) begin
                            cmd[m] <= make_cmd(op_bank_en, word_t'(sw[m] & selected[m]));
                        end
                        bank_en_m1 <= sw[1] & selected[1];
                        if (sw[0] & selected[0]) begin
                            state <= st_bank_m0;
                        end else if (sw[1] & selected[1]) begin
                            state <= st_bank_m1;
                        end else begin
                            state <= st_first_m0;
                        end
                    end
                end
                st_bank_m0: begin
                    if (step) begin
                        state <= bank_en_m1 ? st_bank_m1 : st_first_m0;
                    end else if (next_word) begin
                        cmd[0] <= make_cmd(op_bank_word, sw);
                    end
                end
                st_bank_m1: begin
                    if (step) begin
                        state <= st_first_m0;
                    end else if (next_word) begin
                        cmd[1] <= make_cmd(op_bank_word, sw);
                    end
                end
                st_first_m0: begin
                    if (step) begin
                        cmd[0] <= make_cmd(op_first, sw);
                        state  <= st_first_m1;
                    end
                end
                st_first_m1: begin
                    if (step) begin
                        cmd[1] <= make_cmd(op_first, sw);
                        state  <= st_len_m0;
                    end
                end
                st_len_m0: begin
                    if (step) begin
                        cmd[0] <= make_cmd(op_length, sw);
                        state  <= st_len_m1;
                    end
                end
                st_len_m1: begin
                    if (step) begin
                        cmd[1]      <= make_cmd(op_length, sw);
                        send_issued <= 1'b0;
                        state       <= st_config;
                    end
                end
                st_config: begin
                    if (!send_issued) begin         // op_length of master 1 still in flight
                        for (int m = 0; m < MASTER_COUNT; m++) begin
                            if (selected[m]) begin
                                cmd[m] <= make_cmd(op_send, '0);
                            end
                        end
                        send_issued <= 1'b1;
                    end else if (all_configured) begin
                        state <= st_ready;
                    end
                end
                st_ready: begin
                    if (step) begin
                        state <= st_run;
                    end
                end
                st_run: begin
                    if (all_done) begin
                        state <= st_done;
                    end
                end
                st_done: begin                      // held until reset
                end
                default: begin
                    state <= st_slave_sel;
                end
            endcase
        end
    end

    // start[0] right after the step, start[1] a fixed gap later
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            start   <= '0;
            gap_cnt <= '0;
            gap_run <= 1'b0;
        end else begin
            start <= '0;
            if (state == st_ready && step) begin
                start[0] <= selected[0];
                gap_cnt  <= gap_cnt_t'(COM_START_GAP - 1);
                gap_run  <= 1'b1;
            end else if (gap_run) begin
                if (gap_cnt == '0) begin
                    start[1] <= selected[1];
                    gap_run  <= 1'b0;
                end else begin
                    gap_cnt <= gap_cnt - 1'b1;
                end
            end
        end
    end

    always_comb begin
        lights.idle    = (state == st_slave_sel);
        lights.ready   = (state == st_ready);
        lights.running = (state == st_run);
        lights.done    = (state == st_done);
    end

endmodule

/* rtl/session_top.sv */
`timescale 1ns/1ps

module session_top (
    input  logic                                              clk,
    input  logic                                              rstN,
    input  logic                                              step,
    input  logic                                              next_word,
    input  bus_pkg::word_t                                    sw,
    output logic [bus_pkg::MASTER_COUNT-1:0]                  req,
    output ctrl_pkg::setup_xfer_t [bus_pkg::MASTER_COUNT-1:0] xfer,
    input  logic [bus_pkg::MASTER_COUNT-1:0]                  ack,
    output logic [bus_pkg::MASTER_COUNT-1:0]                  start,
    input  logic [bus_pkg::MASTER_COUNT-1:0]                  com_done,
    output ctrl_pkg::lights_t                                 lights
);
    import bus_pkg::*;
    import ctrl_pkg::*;

    setup_cmd_t [MASTER_COUNT-1:0] cmd;             // per-master setup commands
    logic [MASTER_COUNT-1:0]       configured;

    session_ctrl u_ctrl (
        .clk        (clk),
        .rstN       (rstN),
        .step       (step),
        .next_word  (next_word),
        .sw         (sw),
        .cmd        (cmd),
        .configured (configured),
        .start      (start),
        .com_done   (com_done),
        .lights     (lights)
    );

    master_setup u_setup0 (
        .clk        (clk),
        .rstN       (rstN),
        .cmd        (cmd[0]),
        .configured (configured[0]),
        .req        (req[0]),
        .xfer       (xfer[0]),
        .ack        (ack[0])
    );

    master_setup u_setup1 (
        .clk        (clk),
        .rstN       (rstN),
        .cmd        (cmd[1]),
        .configured (configured[1]),
        .req        (req[1]),
        .xfer       (xfer[1]),
        .ack        (ack[1])
    );

endmodule

/* verification/session_sva.sv */
`timescale 1ns/1ps

module session_sva (
    input logic                                              clk,
    input logic                                              rstN,
    input logic [bus_pkg::MASTER_COUNT-1:0]                  req,
    input logic [bus_pkg::MASTER_COUNT-1:0]                  ack,
    input ctrl_pkg::setup_xfer_t [bus_pkg::MASTER_COUNT-1:0] xfer,
    input logic [bus_pkg::MASTER_COUNT-1:0]                  start
);
    import ctrl_pkg::*;

    int fail_count = 0;                             // watched by the testbench

    for (genvar m = 0; m < 2; m++) begin : g_chan
        a_req_falls_after_ack: assert property (@(posedge clk) disable iff (!rstN)
            $fell(req[m]) |-> ack[m])
        else begin
            $error("req[%0d] dropped before ack", m);
            fail_count = fail_count + 1;
        end

        a_req_rises_ack_low: assert property (@(posedge clk) disable iff (!rstN)
            $rose(req[m]) |-> !ack[m])
        else begin
            $error("req[%0d] rose while ack was high", m);
            fail_count = fail_count + 1;
        end

        a_xfer_stable: assert property (@(posedge clk) disable iff (!rstN)
            (req[m] && $past(req[m])) |-> $stable(xfer[m]))
        else begin
            $error("xfer[%0d] changed while req was high", m);
            fail_count = fail_count + 1;
        end
    end

    // start[0] is a single pulse, start[1] follows after the fixed gap
    a_start0_pulse: assert property (@(posedge clk) disable iff (!rstN)
        start[0] |=> !start[0])
    else begin
        $error("start[0] held longer than one cycle");
        fail_count = fail_count + 1;
    end

    a_start1_gap: assert property (@(posedge clk) disable iff (!rstN)
        $rose(start[0]) |-> ##COM_START_GAP start[1])
    else begin
        $error("start[1] missing after the start gap");
        fail_count = fail_count + 1;
    end

    a_start1_origin: assert property (@(posedge clk) disable iff (!rstN)
        start[1] |-> $past(start[0], COM_START_GAP))
    else begin
        $error("start[1] not preceded by start[0] at the gap");
        fail_count = fail_count + 1;
    end

endmodule

bind session_top session_sva u_sva (
    .clk   (clk),
    .rstN  (rstN),
    .req   (req),
    .ack   (ack),
    .xfer  (xfer),
    .start (start)
);

/* verification/tb_session.sv */
`timescale 1ns/1ps

module tb_session;
    import bus_pkg::*;
    import ctrl_pkg::*;

    // two sessions of about 1500 cycles each at the worst ack delay
    localparam int WATCHDOG_CYCLES = 2 * 1500;

    // lights bits are idle, ready, running, done from msb down
    localparam logic [31:0] ONLY_IDLE    = 32'b1000;
    localparam logic [31:0] ONLY_READY   = 32'b0100;
    localparam logic [31:0] ONLY_RUNNING = 32'b0010;
    localparam logic [31:0] ONLY_DONE    = 32'b0001;

    localparam master_cfg_t HEAD_M0 = '{slave_id: 2'd1, read: 1'b0, burst: 1'b1,
                                        first_addr: 12'd100, last_addr: 12'd120};
    // 2000 + 100 clamped to 2048 - 1
    localparam master_cfg_t HEAD_M1 = '{slave_id: 2'd3, read: 1'b1, burst: 1'b0,
                                        first_addr: 12'd2000, last_addr: 12'd2047};

    logic                          clk       = 1'b0;
    logic                          rstN      = 1'b0;
    logic                          step      = 1'b0;
    logic                          next_word = 1'b0;
    word_t                         sw        = '0;
    logic [MASTER_COUNT-1:0]       ack       = '0;
    logic [MASTER_COUNT-1:0]       com_done  = '0;
    logic [MASTER_COUNT-1:0]       req;
    setup_xfer_t [MASTER_COUNT-1:0] xfer;
    logic [MASTER_COUNT-1:0]       start;
    lights_t                       lights;

    integer      seed = 93;
    setup_xfer_t got0 [$];                          // items seen by master 0
    setup_xfer_t got1 [$];
    word_t       bank_words [3] = '{16'hA1A1, 16'hB2B2, 16'hC3C3};

    session_top u_dut (
        .clk       (clk),
        .rstN      (rstN),
        .step      (step),
        .next_word (next_word),
        .sw        (sw),
        .req       (req),
        .xfer      (xfer),
        .ack       (ack),
        .start     (start),
        .com_done  (com_done),
        .lights    (lights)
    );

    always #20 clk = ~clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic expect_equal(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        assert (actual === expected)
        else fail_run($sformatf("Mismatch at %0t: %s expected %0h, actual %0h",
                                $time, name, expected, actual));
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rstN      <= 1'b0;
        step      <= 1'b0;
        next_word <= 1'b0;
        sw        <= '0;
        com_done  <= '0;
        repeat (5) @(posedge clk);
        rstN <= 1'b1;
        @(posedge clk);
        expect_equal("req", 0, 32'(req));
        expect_equal("start", 0, 32'(start));
        expect_equal("lights", ONLY_IDLE, 32'(lights));
    endtask

    task automatic press(input logic is_word, input word_t value);
        @(posedge clk);
        sw <= value;
        if (is_word) begin
            next_word <= 1'b1;
        end else begin
            step <= 1'b1;
        end
        @(posedge clk);
        step      <= 1'b0;
        next_word <= 1'b0;
    endtask

    // external master side of one setup channel
    task automatic serve_channel(input logic m);
        int wait_cycles;
        forever begin
            @(posedge clk);
            if (req[m] && !ack[m]) begin
                wait_cycles = $unsigned($random(seed)) % 6;
                repeat (wait_cycles) @(posedge clk);
                ack[m] <= 1'b1;
                if (m == 1'b0) begin
                    got0.push_back(xfer[0]);
                end else begin
                    got1.push_back(xfer[1]);
                end
                do @(posedge clk); while (req[m]);
                ack[m] <= 1'b0;
            end
        end
    endtask

    task automatic finish_master(input logic m);
        int wait_cycles;
        forever begin
            @(posedge clk);
            if (start[m]) begin
                wait_cycles = 1 + $unsigned($random(seed)) % 4;
                repeat (wait_cycles) @(posedge clk);
                com_done[m] <= 1'b1;
            end
        end
    endtask

    always @(posedge clk) begin
        if (u_dut.u_sva.fail_count != 0) begin
            fail_run("a bound protocol assertion failed");
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        fail_run("watchdog expired before the sessions finished");
    end

    initial begin
        fork
            serve_channel(1'b0);
            serve_channel(1'b1);
            finish_master(1'b0);
            finish_master(1'b1);
        join_none
        apply_reset();

        press(1'b0, 16'h000D);                      // m0 slave 1, m1 slave 3
        press(1'b0, 16'h0002);                      // m0 write, m1 read
        press(1'b0, 16'h0001);                      // bank on for m0 only
        for (int i = 0; i < 3; i++) begin
            press(1'b1, bank_words[i]);
        end
        press(1'b0, 16'h0000);                      // leave the bank menu
        press(1'b0, 16'd100);
        press(1'b0, 16'd2000);
        press(1'b0, 16'd20);
        press(1'b0, 16'd100);
        while (!lights.ready) @(posedge clk);
        expect_equal("lights", ONLY_READY, 32'(lights));

        expect_equal("master 0 item count", 4, got0.size());
        expect_equal("xfer[0].kind", 32'(kind_head), 32'(got0[0].kind));
        expect_equal("xfer[0].cfg", 32'(HEAD_M0), 32'(got0[0].cfg));
        for (int i = 0; i < 3; i++) begin
            expect_equal($sformatf("xfer[0] word %0d kind", i), 32'(kind_word),
                         32'(got0[i+1].kind));
            expect_equal($sformatf("xfer[0] word %0d data", i), 32'(bank_words[i]),
                         32'(got0[i+1].data));
        end
        expect_equal("master 1 item count", 1, got1.size());
        expect_equal("xfer[1].kind", 32'(kind_head), 32'(got1[0].kind));
        expect_equal("xfer[1].cfg", 32'(HEAD_M1), 32'(got1[0].cfg));

        press(1'b0, 16'h0000);                      // start both masters
        while (lights.ready) @(posedge clk);
        expect_equal("lights", ONLY_RUNNING, 32'(lights));
        while (!lights.done) @(posedge clk);
        expect_equal("lights", ONLY_DONE, 32'(lights));
        expect_equal("com_done", 3, 32'(com_done));    // done only after both masters

        // second session with no slave chosen
        apply_reset();
        press(1'b0, 16'h0000);
        while (!lights.done) begin
            expect_equal("req", 0, 32'(req));
            expect_equal("start", 0, 32'(start));
            @(posedge clk);
        end
        expect_equal("lights", ONLY_DONE, 32'(lights));
        repeat (4) begin
            @(posedge clk);
            expect_equal("req", 0, 32'(req));
            expect_equal("start", 0, 32'(start));
        end
        expect_equal("master 0 item count", 4, got0.size());
        expect_equal("master 1 item count", 1, got1.size());

        if (u_dut.u_sva.fail_count != 0) begin
            fail_run("a bound protocol assertion failed");
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

/* list.f */
rtl/bus_pkg.sv
rtl/ctrl_pkg.sv
rtl/master_setup.sv
rtl/session_ctrl.sv
rtl/session_top.sv
verification/session_sva.sv
verification/tb_session.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_session \
    -f list.f \
    -o sim_session

# keep running past a bound assertion so the testbench can report it
./obj_dir/sim_session +verilator+error+limit+100 | tee sim.log

if grep -q "^\*\* PASS \*\*$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
